//--- compile.f
+incdir+.
iot_types_pkg.sv
iot_fn_pkg.sv
byte_loader.sv
crc3_engine.sv
extreme_tracker.sv
result_mux.sv
iotdf_top.sv
tb_iotdf.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_iotdf
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and pass only if the log shows a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb_iotdf.sv
`timescale 1ns/1ns
`include "iotdf_settings.svh"

module tb_iotdf
  import iot_types_pkg::*,
         iot_fn_pkg::*;
();

  localparam int TOTAL_ITEMS = 6 + 4 * `IOT_GROUP_ITEMS + 2;
  // worst case of 4 cycles per byte doubled for margin
  localparam int CYCLE_LIMIT = 2 * 4 * TOTAL_ITEMS * `IOT_ITEM_BYTES + 100;

  logic       clk;
  logic       rst;
  logic       i_in_en;
  byte_t      i_iot_in;
  logic [2:0] i_fn_sel;
  logic       o_valid;
  item_t      o_iot_out;

  // high together with the byte that completes an item
  logic       drv_last;
  logic [2:0] last_d;
  logic       seen_last;
  fn_t        run_fn;
  logic       trk_run;

  logic [31:0] lfsr;
  item_t       items [0:2*`IOT_GROUP_ITEMS-1];
  item_t       exp_q [$];
  item_t       exp_head;
  int          pushed;
  int          popped;
  int          value_errs = 0;
  int          other_errs = 0;
  int          cycles = 0;

  iotdf_top iotdf_top_inst (
    .clk       (clk),
    .rst       (rst),
    .i_in_en   (i_in_en),
    .i_iot_in  (i_iot_in),
    .i_fn_sel  (i_fn_sel),
    .o_valid   (o_valid),
    .o_iot_out (o_iot_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // galois lfsr with taps for x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'hD000_0001;
    end
    return n;
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // long division of item * x^3 by 1011
  function automatic crc_t ref_crc(item_t item);
    logic [`IOT_ITEM_W+`IOT_CRC_W-1:0] r;
    r = {item, {`IOT_CRC_W{1'b0}}};
    for (int i = `IOT_ITEM_W + `IOT_CRC_W - 1; i >= `IOT_CRC_W; i--) begin
      if (r[i]) begin
        r[i -: `IOT_CRC_W+1] = r[i -: `IOT_CRC_W+1] ^ {1'b1, `IOT_CRC_POLY};
      end
    end
    return r[`IOT_CRC_W-1:0];
  endfunction

  // expected pair read from the ends of a sorted copy of one group
  task automatic push_pair(input int base, input logic want_max);
    item_t srt [0:`IOT_GROUP_ITEMS-1];
    item_t t;
    for (int k = 0; k < `IOT_GROUP_ITEMS; k++) begin
      srt[k] = items[base+k];
    end
    // bubble sort into ascending order
    for (int p = 0; p < `IOT_GROUP_ITEMS - 1; p++) begin
      for (int j = 0; j < `IOT_GROUP_ITEMS - 1 - p; j++) begin
        if (srt[j] > srt[j+1]) begin
          t        = srt[j];
          srt[j]   = srt[j+1];
          srt[j+1] = t;
        end
      end
    end
    if (want_max) begin
      exp_q.push_back(srt[`IOT_GROUP_ITEMS-1]);
      exp_q.push_back(srt[`IOT_GROUP_ITEMS-2]);
    end else begin
      exp_q.push_back(srt[0]);
      exp_q.push_back(srt[1]);
    end
    pushed += 2;
  endtask

  // msb byte first with 0 to 3 idle cycles before each byte
  task automatic send_item(input item_t item);
    logic [31:0] r;
    int          gap;
    for (int b = 0; b < `IOT_ITEM_BYTES; b++) begin
      take_bits(2, r);
      gap = int'(r[1:0]);
      repeat (gap) begin
        @(posedge clk);
        i_in_en  <= 1'b0;
        drv_last <= 1'b0;
      end
      @(posedge clk);
      i_in_en  <= 1'b1;
      i_iot_in <= item[`IOT_ITEM_W-1-`IOT_BYTE_W*b -: `IOT_BYTE_W];
      drv_last <= (b == `IOT_ITEM_BYTES - 1);
    end
  endtask

  task automatic run_case(input logic [2:0] code, input fn_t fn, input int nitems,
                          input logic dup_min);
    logic [31:0] r;
    int          m;
    @(posedge clk);
    rst      <= 1'b1;
    i_in_en  <= 1'b0;
    drv_last <= 1'b0;
    i_fn_sel <= code;
    @(posedge clk);
    // items and expected results are built while reset is high
    exp_q.delete();
    pushed  = 0;
    run_fn  = fn;
    trk_run = (fn == FN_TOP2MAX || fn == FN_LAST2MIN);
    for (int i = 0; i < nitems; i++) begin
      items[i] = '0;
      for (int b = 0; b < `IOT_ITEM_BYTES; b++) begin
        take_bits(`IOT_BYTE_W, r);
        items[i] = {items[i][`IOT_ITEM_W-`IOT_BYTE_W-1:0], r[`IOT_BYTE_W-1:0]};
      end
    end
    if (dup_min) begin
      // copy the group minimum over another slot
      m = 0;
      for (int k = 1; k < `IOT_GROUP_ITEMS; k++) begin
        if (items[k] < items[m]) begin
          m = k;
        end
      end
      items[(m + 3) % `IOT_GROUP_ITEMS] = items[m];
    end
    if (fn == FN_CRC_GEN) begin
      for (int i = 0; i < nitems; i++) begin
        exp_q.push_back(item_t'(ref_crc(items[i])));
        pushed++;
      end
    end else if (trk_run) begin
      for (int g = 0; g < nitems / `IOT_GROUP_ITEMS; g++) begin
        push_pair(g * `IOT_GROUP_ITEMS, fn == FN_TOP2MAX);
      end
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < nitems; i++) begin
      send_item(items[i]);
    end
    @(posedge clk);
    i_in_en  <= 1'b0;
    drv_last <= 1'b0;
    while (popped < pushed) begin
      @(posedge clk);
    end
    // results land within 4 edges, so a quiet tail catches extra pulses
    repeat (6) @(posedge clk);
    if (popped != pushed) begin
      other_errs++;
      $display("run with code %0d gave %0d results where %0d were expected",
               code, popped, pushed);
    end
  endtask

  // result counting and the expected value for the next pulse
  always @(posedge clk or posedge rst) begin : result_track
    int next_pop;
    if (rst) begin
      last_d    <= '0;
      seen_last <= 1'b0;
      popped    <= 0;
      exp_head  <= '0;
    end else begin
      next_pop = popped + (o_valid ? 1 : 0);
      last_d <= {last_d[1:0], i_in_en && drv_last};
      if (i_in_en && drv_last) begin
        seen_last <= 1'b1;
      end
      popped   <= next_pop;
      exp_head <= (next_pop < pushed) ? exp_q[next_pop] : '0;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with results still missing", cycles);
      $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
      $display("Test FAILED");
      $finish;
    end
  end

  assert property (@(posedge clk) disable iff (rst) o_valid |-> (o_iot_out == exp_head))
    else begin
      value_errs = value_errs + 1;
      $display("[ERROR] %0t o_iot_out expected %h got %h", $time,
               $sampled(exp_head), $sampled(o_iot_out));
    end

  assert property (@(posedge clk) disable iff (rst) o_valid |-> (popped < pushed))
    else begin
      other_errs = other_errs + 1;
      $display("o_valid pulsed at %0t with no result expected", $time);
    end

  // nothing leaves the DUT before the first complete item
  assert property (@(posedge clk) disable iff (rst) !seen_last |-> !o_valid)
    else begin
      other_errs = other_errs + 1;
      $display("o_valid high at %0t before any item was complete", $time);
    end

  assert property (@(posedge clk) disable iff (rst) !seen_last |-> (o_iot_out == '0))
    else begin
      value_errs = value_errs + 1;
      $display("[ERROR] %0t o_iot_out expected %h got %h", $time,
               item_t'(0), $sampled(o_iot_out));
    end

  assert property (@(posedge clk) disable iff (rst)
    (run_fn == FN_CRC_GEN) |-> (o_valid == last_d[2]))
    else begin
      other_errs = other_errs + 1;
      $display("CRC result at %0t not exactly 3 edges after the last byte", $time);
    end

  assert property (@(posedge clk) disable iff (rst) (trk_run && $rose(o_valid)) |=> o_valid)
    else begin
      other_errs = other_errs + 1;
      $display("min/max result at %0t not followed by its runner-up", $time);
    end

  assert property (@(posedge clk) disable iff (rst)
    (trk_run && o_valid && $past(o_valid)) |=> !o_valid)
    else begin
      other_errs = other_errs + 1;
      $display("more than two adjacent min/max results at %0t", $time);
    end

  initial begin
    rst      = 1'b1;
    i_in_en  = 1'b0;
    i_iot_in = '0;
    i_fn_sel = '0;
    drv_last = 1'b0;
    run_fn   = FN_NONE;
    trk_run  = 1'b0;
    pushed   = 0;
    lfsr     = 32'd80880;
    run_case(3'd3, FN_CRC_GEN, 6, 1'b0);
    run_case(3'd4, FN_TOP2MAX, 2 * `IOT_GROUP_ITEMS, 1'b0);
    run_case(3'd5, FN_LAST2MIN, 2 * `IOT_GROUP_ITEMS, 1'b1);
    // dropped code 1 gives no output
    run_case(3'd1, FN_NONE, 2, 1'b0);
    $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- iotdf_top.sv
`timescale 1ns/1ns

module iotdf_top
  import iot_types_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       i_in_en,
  input  byte_t      i_iot_in,
  input  logic [2:0] i_fn_sel,
  output logic       o_valid,
  output item_t      o_iot_out
);

  item_t item_data;
  logic  item_strobe;
  logic  crc_start;
  logic  trk_start;
  logic  trk_find_max;
  crc_t  crc_value;
  logic  crc_done;
  item_t trk_value;
  logic  trk_done;

  byte_loader byte_loader_inst (
    .clk           (clk),
    .rst           (rst),
    .i_in_en       (i_in_en),
    .i_byte        (i_iot_in),
    .o_item        (item_data),
    .o_item_strobe (item_strobe)
  );

  crc3_engine crc3_engine_inst (
    .clk     (clk),
    .rst     (rst),
    .i_start (crc_start),
    .i_item  (item_data),
    .o_crc   (crc_value),
    .o_done  (crc_done)
  );

  extreme_tracker extreme_tracker_inst (
    .clk        (clk),
    .rst        (rst),
    .i_start    (trk_start),
    .i_find_max (trk_find_max),
    .i_item     (item_data),
    .o_value    (trk_value),
    .o_done     (trk_done)
  );

  result_mux result_mux_inst (
    .clk            (clk),
    .rst            (rst),
    .i_in_en        (i_in_en),
    .i_fn_sel       (i_fn_sel),
    .i_item_strobe  (item_strobe),
    .i_crc          (crc_value),
    .i_crc_done     (crc_done),
    .i_trk_value    (trk_value),
    .i_trk_done     (trk_done),
    .o_crc_start    (crc_start),
    .o_trk_start    (trk_start),
    .o_trk_find_max (trk_find_max),
    .o_valid        (o_valid),
    .o_iot_out      (o_iot_out)
  );

endmodule

//--- result_mux.sv
`timescale 1ns/1ns

module result_mux
  import iot_types_pkg::*,
         iot_fn_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       i_in_en,
  input  logic [2:0] i_fn_sel,
  input  logic       i_item_strobe,
  input  crc_t       i_crc,
  input  logic       i_crc_done,
  input  item_t      i_trk_value,
  input  logic       i_trk_done,
  output logic       o_crc_start,
  output logic       o_trk_start,
  output logic       o_trk_find_max,
  output logic       o_valid,
  output item_t      o_iot_out
);

  mux_state_t state;
  fn_t        fn;

  // unsupported codes produce no output
  function automatic fn_t decode_fn(logic [2:0] code);
    case (code)
      3'd3:    return FN_CRC_GEN;
      3'd4:    return FN_TOP2MAX;
      3'd5:    return FN_LAST2MIN;
      default: return FN_NONE;
    endcase
  endfunction

  // function code is taken once, at the first byte
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= MUX_WAIT_FN;
      fn    <= FN_NONE;
    end else if (state == MUX_WAIT_FN && i_in_en) begin
      fn    <= decode_fn(i_fn_sel);
      state <= MUX_RUN;
    end
  end

  // route item strobes to the active engine
  assign o_crc_start    = i_item_strobe && (fn == FN_CRC_GEN);
  assign o_trk_start    = i_item_strobe && (fn == FN_TOP2MAX || fn == FN_LAST2MIN);
  assign o_trk_find_max = (fn == FN_TOP2MAX);

  // registered output stage
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_valid   <= 1'b0;
      o_iot_out <= '0;
    end else begin
      o_valid <= i_crc_done || i_trk_done;
      if (i_crc_done) begin
        o_iot_out <= item_t'(i_crc);
      end else if (i_trk_done) begin
        o_iot_out <= i_trk_value;
      end
    end
  end

  // only one engine is ever enabled for a run
  assert property (@(posedge clk) disable iff (rst)
    !(i_crc_done && i_trk_done))
    else $error("result_mux: crc and tracker done at the same time");

endmodule

//--- extreme_tracker.sv
`timescale 1ns/1ns
`include "iotdf_settings.svh"

module extreme_tracker
  import iot_types_pkg::*,
         iot_fn_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  i_start,
  input  logic  i_find_max,
  input  item_t i_item,
  output item_t o_value,
  output logic  o_done
);

  localparam item_idx_t LAST_ITEM = item_idx_t'(`IOT_GROUP_ITEMS - 1);

  trk_state_t state;
  item_idx_t  item_cnt;
  logic       last_item;
  logic       emit_first;

  // running pair
  item_t best;
  item_t second;
  item_t best_nxt;
  item_t second_nxt;

  // runner-up parked for the second result
  item_t hold_second;

  // strict ordering, larger for max mode and smaller for min mode
  function automatic logic beats(item_t a, item_t b, logic find_max);
    return find_max ? (a > b) : (a < b);
  endfunction

  assign last_item  = (item_cnt == LAST_ITEM);
  assign emit_first = i_start && last_item;

  // next running pair
  always_comb begin
    best_nxt   = best;
    second_nxt = second;
    if (item_cnt == '0) begin
      // group seed, second starts at the weakest value
      best_nxt   = i_item;
      second_nxt = i_find_max ? '0 : '1;
    end else if (beats(i_item, best, i_find_max)) begin
      best_nxt   = i_item;
      second_nxt = best;
    end else if (!beats(second, i_item, i_find_max)) begin
      // a tie with best lands here too
      second_nxt = i_item;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= TRK_COLLECT;
      item_cnt <= '0;
      o_done   <= 1'b0;
    end else begin
      o_done <= emit_first || (state == TRK_SECOND);
      if (i_start) begin
        item_cnt <= item_cnt + 1'b1;
      end
      case (state)
        TRK_COLLECT: begin
          if (emit_first) begin
            state <= TRK_SECOND;
          end
        end
        TRK_SECOND: begin
          state <= TRK_COLLECT;
        end
        default: begin
          state <= TRK_COLLECT;
        end
      endcase
    end
  end

  // output pair is split off so the next group can start right away
  always_ff @(posedge clk) begin
    if (i_start) begin
      best   <= best_nxt;
      second <= second_nxt;
    end
    if (emit_first) begin
      o_value     <= best_nxt;
      hold_second <= second_nxt;
    end else if (state == TRK_SECOND) begin
      o_value <= hold_second;
    end
  end

  // each group gives exactly two results back to back
  assert property (@(posedge clk) disable iff (rst)
    $rose(o_done) |=> o_done ##1 !o_done)
    else $error("extreme_tracker: done pulses not in an adjacent pair");

endmodule

//--- crc3_engine.sv
`timescale 1ns/1ns
`include "iotdf_settings.svh"

module crc3_engine
  import iot_types_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  i_start,
  input  item_t i_item,
  output crc_t  o_crc,
  output logic  o_done
);

  crc_t crc_calc;

  // remainder of item * x^3, msb first
  // same bit-serial division as an lfsr, unrolled over the whole item
  function automatic crc_t crc_of(item_t item);
    crc_t rem;
    logic fb;
    rem = '0;
    for (int i = `IOT_ITEM_W - 1; i >= 0; i--) begin
      fb  = rem[`IOT_CRC_W-1] ^ item[i];
      rem = {rem[`IOT_CRC_W-2:0], 1'b0};
      if (fb) begin
        rem = rem ^ crc_t'(`IOT_CRC_POLY);
      end
    end
    return rem;
  endfunction

  assign crc_calc = crc_of(i_item);

  // done pulse
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_done <= 1'b0;
    end else begin
      o_done <= i_start;
    end
  end

  // remainder only loads on a new item
  always_ff @(posedge clk) begin
    if (i_start) begin
      o_crc <= crc_calc;
    end
  end

  // done is exactly one cycle behind start, never earlier or later
  assert property (@(posedge clk) disable iff (rst)
    i_start |=> o_done)
    else $error("crc3_engine: done missing one cycle after start");

  assert property (@(posedge clk) disable iff (rst)
    o_done |-> $past(i_start))
    else $error("crc3_engine: done without a start on the previous cycle");

endmodule

//--- byte_loader.sv
`timescale 1ns/1ns
`include "iotdf_settings.svh"

module byte_loader
  import iot_types_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  i_in_en,
  input  byte_t i_byte,
  output item_t o_item,
  output logic  o_item_strobe
);

  localparam byte_idx_t LAST_BYTE = byte_idx_t'(`IOT_ITEM_BYTES - 1);

  byte_idx_t byte_cnt;

  // byte counter and completion strobe
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      byte_cnt      <= '0;
      o_item_strobe <= 1'b0;
    end else begin
      // wraps to zero after the last byte of an item
      if (i_in_en) begin
        byte_cnt <= byte_cnt + 1'b1;
      end
      o_item_strobe <= i_in_en && (byte_cnt == LAST_BYTE);
    end
  end

  // shift in from the low end, first byte ends up on top
  always_ff @(posedge clk) begin
    if (i_in_en) begin
      o_item <= {o_item[`IOT_ITEM_W-`IOT_BYTE_W-1:0], i_byte};
    end
  end

  // an item takes sixteen accepted bytes, so strobes never touch
  assert property (@(posedge clk) disable iff (rst)
    o_item_strobe |=> !o_item_strobe)
    else $error("byte_loader: item strobe high on two cycles in a row");

endmodule

//--- iot_fn_pkg.sv
package iot_fn_pkg;

  // function select codes
  // codes 1, 2, 6 and 7 fold into FN_NONE
  typedef enum logic [2:0] {
    FN_NONE     = 3'd0,
    FN_CRC_GEN  = 3'd3,
    FN_TOP2MAX  = 3'd4,
    FN_LAST2MIN = 3'd5
  } fn_t;

  // result_mux states
  typedef enum logic {
    MUX_WAIT_FN,
    MUX_RUN
  } mux_state_t;

  // extreme_tracker states
  typedef enum logic {
    TRK_COLLECT,
    TRK_SECOND
  } trk_state_t;

endpackage

//--- iot_types_pkg.sv
`include "iotdf_settings.svh"

package iot_types_pkg;

  // one strobed input byte
  typedef logic [`IOT_BYTE_W-1:0] byte_t;

  // a whole data item, also the width of the output word
  typedef logic [`IOT_ITEM_W-1:0] item_t;

  // crc remainder
  typedef logic [`IOT_CRC_W-1:0] crc_t;

  // byte position inside an item, wraps after the last byte
  typedef logic [$clog2(`IOT_ITEM_BYTES)-1:0] byte_idx_t;

  // item position inside a min/max group
  typedef logic [$clog2(`IOT_GROUP_ITEMS)-1:0] item_idx_t;

endpackage

//--- iotdf_settings.svh
`ifndef IOTDF_SETTINGS_SVH
`define IOTDF_SETTINGS_SVH

// input side
// one byte per strobe
`define IOT_BYTE_W 8

// sixteen bytes make one item
`define IOT_ITEM_BYTES 16

// item and output word width
`define IOT_ITEM_W 128

// min/max grouping
// results come out once per group of this many items
`define IOT_GROUP_ITEMS 8

// crc generator x^3 + x + 1
`define IOT_CRC_W 3

// low bits of the generator, leading x^3 term implied
`define IOT_CRC_POLY 3'b011

`endif
